// ==== dv/tb_clkgen.sv ====
// Testbench clock and reset
// 100 ns clock, reset held high for the first four cycles

`timescale 1ns/1ps

module tb_clkgen
(
    output logic clk,
    output logic reset
);

    // Half of the 100 ns period
    initial
    begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // Released on a falling edge like every other input
    initial
    begin
        reset = 1'b1;
        repeat (4) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
    end

endmodule

// ==== dv/tb_hc_channel.sv ====
// Host-channel testbench
// Runs pass-through, source, loopback and sink traffic through the top level
// and checks every line taken at the host and client ports against a scoreboard

`timescale 1ns/1ps

module tb_hc_channel
    import hc_cfg_pkg::*;
    import hc_msg_pkg::*;
();

    // Limit sits well above the few hundred cycles the tests take
    localparam int MAX_CYCLES = 6000;
    localparam t_hc_line LOW_MASK = 64'h0000_0000_FFFF_FFFF;

    logic                     clk;
    logic                     reset;
    logic                     csr_wr_en;
    logic [HC_CSR_ADDR_W-1:0] csr_addr;
    logic [HC_CSR_DATA_W-1:0] csr_wr_data;
    logic [HC_CSR_DATA_W-1:0] csr_rd_data;
    logic                     host_rx_valid;
    t_hc_line                 host_rx_data;
    logic                     host_rx_full;
    logic                     host_tx_valid;
    t_hc_line                 host_tx_data;
    logic                     host_tx_rdy;
    t_hc_line                 client_rx_data;
    logic                     client_rx_rdy;
    logic                     client_rx_enable;
    t_hc_line                 client_tx_data;
    logic                     client_tx_rdy;
    logic                     client_tx_enable;

    // Scoreboard of expected lines and compare masks in arrival order
    t_hc_line tx_exp_q[$];
    t_hc_line tx_mask_q[$];
    t_hc_line rx_exp_q[$];
    // Line due at the next rising edge
    t_hc_line exp_tx_line;
    t_hc_line exp_tx_mask;
    t_hc_line exp_rx_line;
    int       tx_outstanding;
    int       rx_outstanding;
    logic     in_test;
    logic     tx_closed;
    logic     client_hold;
    int       rx_level;
    logic     rd_check;
    t_hc_line rd_expect;
    logic [15:0] lfsr_state;
    int       cycle_count;
    int       tests_run;

    tb_clkgen u_clkgen (
        .clk   (clk),
        .reset (reset)
    );

    hc_channel_top u_hc_channel_top (
        .clk              (clk),
        .reset            (reset),
        .csr_wr_en        (csr_wr_en),
        .csr_addr         (csr_addr),
        .csr_wr_data      (csr_wr_data),
        .csr_rd_data      (csr_rd_data),
        .host_rx_valid    (host_rx_valid),
        .host_rx_data     (host_rx_data),
        .host_rx_full     (host_rx_full),
        .host_tx_valid    (host_tx_valid),
        .host_tx_data     (host_tx_data),
        .host_tx_rdy      (host_tx_rdy),
        .client_rx_data   (client_rx_data),
        .client_rx_rdy    (client_rx_rdy),
        .client_rx_enable (client_rx_enable),
        .client_tx_data   (client_tx_data),
        .client_tx_rdy    (client_tx_rdy),
        .client_tx_enable (client_tx_enable)
    );

    task automatic fail_check(input string msg);
        $display("FAILED at time %0t: %s", $time, msg);
        $display("Test failures found");
        $fatal(1, "Stopped at first wrong value");
    endtask

    task automatic abort_run(input string msg);
        $display("Error: %s", msg);
        $display("Test failures found");
        $fatal(1, "Stopped at first error");
    endtask

    // Galois LFSR with taps x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
    endfunction

    // One LFSR step per bit taken
    function automatic logic [63:0] rand_bits(input int n);
        logic [63:0] v;
        v = '0;
        for (int i = 0; i < n; i++)
        begin
            v          = {v[62:0], lfsr_state[0]};
            lfsr_state = lfsr_next(lfsr_state);
        end
        return v;
    endfunction

    // Falling edge clears strobes, drives host and client sinks and updates the scoreboard
    task automatic tick();
        logic [63:0] r;
        @(negedge clk);
        // Receive FIFO level as seen by the host and client
        // Lines pushed during a test are popped by the tester
        if (host_rx_valid && !in_test)
            rx_level++;
        if (client_rx_enable)
            rx_level--;
        host_rx_valid    = 1'b0;
        client_tx_enable = 1'b0;
        csr_wr_en        = 1'b0;
        rd_check         = 1'b0;
        // Host takes lines about three cycles in four
        r           = rand_bits(2);
        host_tx_rdy = (r[1:0] != 2'b00);
        tx_outstanding = tx_exp_q.size();
        if (host_tx_valid && host_tx_rdy && (tx_exp_q.size() != 0))
        begin
            exp_tx_line = tx_exp_q.pop_front();
            exp_tx_mask = tx_mask_q.pop_front();
        end
        // Client takes whatever it is offered unless it holds off
        client_rx_enable = client_rx_rdy && !client_hold;
        rx_outstanding   = rx_exp_q.size();
        if (client_rx_enable && (rx_exp_q.size() != 0))
            exp_rx_line = rx_exp_q.pop_front();
    endtask

    task automatic host_push(input t_hc_line line);
        tick();
        while (host_rx_full)
            tick();
        host_rx_valid = 1'b1;
        host_rx_data  = line;
    endtask

    task automatic client_send(input t_hc_line line);
        tick();
        while (!client_tx_rdy)
            tick();
        client_tx_enable = 1'b1;
        client_tx_data   = line;
    endtask

    task automatic csr_write(input logic [HC_CSR_ADDR_W-1:0] addr, input t_hc_line data);
        tick();
        csr_wr_en   = 1'b1;
        csr_addr    = addr;
        csr_wr_data = data;
    endtask

    task automatic csr_check(input logic [HC_CSR_ADDR_W-1:0] addr, input t_hc_line value);
        tick();
        csr_addr  = addr;
        rd_expect = value;
        rd_check  = 1'b1;
        tick();
    endtask

    // Request is registered first, the tester switches one edge later
    task automatic start_test(input t_hc_mode mode, input logic [HC_COUNT_W-1:0] count);
        csr_write(HC_CSR_TEST, {31'b0, count, mode});
        tick();
        tick();
        tests_run++;
    endtask

    // Idle tail lets a stray line show up at either port
    task automatic drain();
        while ((tx_exp_q.size() != 0) || (rx_exp_q.size() != 0))
            tick();
        repeat (6) tick();
    endtask

    host_tx_line_chk: assert property (@(posedge clk) disable iff (reset)
        (host_tx_valid && host_tx_rdy) |->
            ((host_tx_data & exp_tx_mask) == (exp_tx_line & exp_tx_mask)))
        else fail_check($sformatf("host_tx line differs, expected %h under mask %h",
                                  exp_tx_line, exp_tx_mask));

    host_tx_stray_chk: assert property (@(posedge clk) disable iff (reset)
        host_tx_valid |-> (tx_outstanding != 0))
        else abort_run("a line reached the host that no test produced");

    client_rx_line_chk: assert property (@(posedge clk) disable iff (reset)
        client_rx_enable |-> (client_rx_data == exp_rx_line))
        else fail_check($sformatf("client_rx line differs, expected %h", exp_rx_line));

    client_rx_stray_chk: assert property (@(posedge clk) disable iff (reset)
        client_rx_rdy |-> (rx_outstanding != 0))
        else abort_run("the client was offered a line it should not get");

    // Full exactly when the host has filled every entry
    rx_full_chk: assert property (@(posedge clk) disable iff (reset)
        !in_test |-> (host_rx_full == (rx_level == HC_FIFO_DEPTH)))
        else fail_check($sformatf("host_rx_full wrong with %0d lines held", rx_level));

    // Test modes own the receive FIFO
    test_quiet_chk: assert property (@(posedge clk) disable iff (reset)
        in_test |-> !client_rx_rdy)
        else abort_run("client_rx_rdy went high during a test");

    tx_closed_chk: assert property (@(posedge clk) disable iff (reset)
        tx_closed |-> !client_tx_rdy)
        else abort_run("client_tx_rdy went high with the user channel off");

    readback_chk: assert property (@(posedge clk) disable iff (reset)
        rd_check |-> (csr_rd_data == rd_expect))
        else fail_check($sformatf("CSR %0d read back wrong, expected %h", csr_addr, rd_expect));

    always @(posedge clk)
    begin
        cycle_count = cycle_count + 1;
        if (cycle_count >= MAX_CYCLES)
            abort_run($sformatf("run did not finish within %0d cycles", MAX_CYCLES));
    end

    initial
    begin
        t_hc_line line;
        t_hc_line marker;
        csr_wr_en        = 1'b0;
        csr_addr         = '0;
        csr_wr_data      = '0;
        host_rx_valid    = 1'b0;
        host_rx_data     = '0;
        host_tx_rdy      = 1'b0;
        client_rx_enable = 1'b0;
        client_tx_data   = '0;
        client_tx_enable = 1'b0;
        exp_tx_line      = '0;
        exp_tx_mask      = '0;
        exp_rx_line      = '0;
        tx_outstanding   = 0;
        rx_outstanding   = 0;
        in_test          = 1'b0;
        tx_closed        = 1'b1;
        client_hold      = 1'b0;
        rx_level         = 0;
        rd_check         = 1'b0;
        rd_expect        = '0;
        lfsr_state       = 16'd14243;
        cycle_count      = 0;
        tests_run        = 0;
        @(negedge reset);

        csr_check(HC_CSR_DONE, '0);
        csr_check(HC_CSR_CTRL, '0);
        // Host to client in order while the user channel is still off
        for (int i = 0; i < 8; i++)
        begin
            line = rand_bits(64);
            rx_exp_q.push_back(line);
            host_push(line);
        end
        drain();
        // Receive FIFO fills while the client holds off
        client_hold = 1'b1;
        for (int i = 0; i < HC_FIFO_DEPTH; i++)
        begin
            line = rand_bits(64);
            rx_exp_q.push_back(line);
            host_push(line);
        end
        repeat (2) tick();
        client_hold = 1'b0;
        drain();
        // Client to host once the channel is on
        tx_closed = 1'b0;
        csr_write(HC_CSR_CTRL, 64'd1);
        for (int i = 0; i < 8; i++)
        begin
            line = rand_bits(64);
            tx_exp_q.push_back(line);
            tx_mask_q.push_back('1);
            client_send(line);
        end
        drain();

        // Source counts 5 down to 1 with the last flag on count 1
        for (int n = 5; n >= 1; n--)
        begin
            line = {32'b0, HC_COUNT_W'(n), (n == 1)};
            tx_exp_q.push_back(line);
            tx_mask_q.push_back(LOW_MASK);
        end
        start_test(SOURCE, 31'd5);
        in_test = 1'b1;
        drain();
        in_test = 1'b0;
        csr_check(HC_CSR_DONE, 64'(tests_run));

        // Loopback returns the low half of each host line
        start_test(LOOPBACK, '0);
        in_test = 1'b1;
        for (int i = 0; i < 6; i++)
        begin
            line    = rand_bits(64);
            line[0] = (i == 5);
            tx_exp_q.push_back(line);
            tx_mask_q.push_back(LOW_MASK);
            host_push(line);
        end
        drain();
        in_test = 1'b0;
        // Normal routing again after the test
        line = rand_bits(64);
        rx_exp_q.push_back(line);
        host_push(line);
        drain();
        csr_check(HC_CSR_DONE, 64'(tests_run));

        // Sink eats the host lines and sends the held client word once
        marker         = rand_bits(64);
        client_tx_data = marker;
        tx_exp_q.push_back(marker);
        tx_mask_q.push_back('1);
        start_test(SINK, '0);
        in_test = 1'b1;
        for (int i = 0; i < 4; i++)
        begin
            line    = rand_bits(64);
            line[0] = (i == 3);
            host_push(line);
        end
        drain();
        in_test = 1'b0;

        csr_check(HC_CSR_DONE, 64'(tests_run));
        csr_check(HC_CSR_CTRL, 64'd1);
        tick();
        $display("All tests passed!");
        $finish;
    end

endmodule

// ==== hc_tester.f ====
src/hc_cfg_pkg.sv
src/hc_msg_pkg.sv
src/hc_csr_regs.sv
src/hc_chan_fifo.sv
src/hc_tester.sv
src/hc_channel_top.sv
dv/tb_clkgen.sv
dv/tb_hc_channel.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build the host-channel testbench with Verilator and run it.
# The exit status is nonzero when the build fails or the run ends in $fatal.
cd "$(dirname "$0")" &&
verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module tb_hc_channel -f hc_tester.f \
    -Mdir obj_dir -o sim_hc_channel &&
./obj_dir/sim_hc_channel || { echo "Simulation did not complete cleanly"; exit 1; }

// ==== src/hc_cfg_pkg.sv ====
// Host-channel configuration definitions
// CSR map, test mode encoding, FIFO sizing and counter widths

package hc_cfg_pkg;

    // CSR port sizing
    localparam int HC_CSR_ADDR_W = 2;
    localparam int HC_CSR_DATA_W = 64;

    // Register addresses
    localparam logic [HC_CSR_ADDR_W-1:0] HC_CSR_CTRL = 2'd0;
    // Write-only with mode in bits 1..0 and source count in bits 32..2
    localparam logic [HC_CSR_ADDR_W-1:0] HC_CSR_TEST = 2'd1;
    // Read-only completed test count
    localparam logic [HC_CSR_ADDR_W-1:0] HC_CSR_DONE = 2'd2;

    // Tester modes
    typedef enum logic [1:0]
    {
        NORMAL   = 2'd0,
        SINK     = 2'd1,
        SOURCE   = 2'd2,
        LOOPBACK = 2'd3
    } t_hc_mode;

    // Counter widths
    localparam int HC_COUNT_W = 31;
    localparam int HC_DONE_W  = 16;

    // Channel FIFO sizing with a power-of-two depth
    localparam int HC_FIFO_DEPTH = 8;
    localparam int HC_FIFO_PTR_W = 3;

endpackage

// ==== src/hc_chan_fifo.sv ====
// Host channel FIFO
// First-word-fall-through circular buffer of message lines,
// used for both the receive and the transmit direction

`timescale 1ns/1ps

module hc_chan_fifo
    import hc_cfg_pkg::*;
    import hc_msg_pkg::*;
(
    input  logic     clk,
    input  logic     reset,
    input  logic     push,
    input  t_hc_line push_data,
    input  logic     pop,
    output t_hc_line pop_data,
    output logic     not_empty,
    output logic     not_full
);

    t_hc_line                 mem [HC_FIFO_DEPTH];
    logic [HC_FIFO_PTR_W-1:0] wr_ptr;
    logic [HC_FIFO_PTR_W-1:0] rd_ptr;
    // One extra bit to tell full from empty
    logic [HC_FIFO_PTR_W:0]   count;

    // Line storage
    always_ff @(posedge clk)
    begin
        if (push)
            mem[wr_ptr] <= push_data;
    end

    // Pointers wrap on their own since depth is a power of two
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end
        else
        begin
            if (push)
                wr_ptr <= wr_ptr + 1'b1;
            if (pop)
                rd_ptr <= rd_ptr + 1'b1;
            // Simultaneous push and pop leaves occupancy unchanged
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // Oldest line is always on the output
    assign pop_data  = mem[rd_ptr];
    assign not_empty = (count != '0);
    assign not_full  = (count != (HC_FIFO_PTR_W+1)'(HC_FIFO_DEPTH));

    assert property (@(posedge clk) disable iff (reset) push |-> not_full)
        else $error("Push into full channel FIFO");

    assert property (@(posedge clk) disable iff (reset) pop |-> not_empty)
        else $error("Pop from empty channel FIFO");

endmodule

// ==== src/hc_channel_top.sv ====
// Host-channel top level
// Register block, receive and transmit FIFOs and the test node

`timescale 1ns/1ps

module hc_channel_top
    import hc_cfg_pkg::*;
    import hc_msg_pkg::*;
(
    input  logic                     clk,
    input  logic                     reset,

    // CSR port
    input  logic                     csr_wr_en,
    input  logic [HC_CSR_ADDR_W-1:0] csr_addr,
    input  logic [HC_CSR_DATA_W-1:0] csr_wr_data,
    output logic [HC_CSR_DATA_W-1:0] csr_rd_data,

    // Host receive side
    input  logic                     host_rx_valid,
    input  t_hc_line                 host_rx_data,
    output logic                     host_rx_full,

    // Host transmit side
    output logic                     host_tx_valid,
    output t_hc_line                 host_tx_data,
    input  logic                     host_tx_rdy,

    // Client side
    output t_hc_line                 client_rx_data,
    output logic                     client_rx_rdy,
    input  logic                     client_rx_enable,
    input  t_hc_line                 client_tx_data,
    output logic                     client_tx_rdy,
    input  logic                     client_tx_enable
);

    // Register block to tester
    logic                  user_chan_en;
    t_hc_mode              test_req_mode;
    logic [HC_COUNT_W-1:0] test_req_count;
    logic                  test_done;

    // FIFO to tester
    t_hc_line rx_data;
    logic     rx_rdy;
    logic     rx_enable;
    logic     rx_not_full;
    t_hc_line tx_data;
    logic     tx_rdy;
    logic     tx_enable;
    logic     tx_pop;

    assign host_rx_full = !rx_not_full;
    // Host takes a line whenever one is shown and it is ready
    assign tx_pop       = host_tx_valid && host_tx_rdy;

    hc_csr_regs u_regs (
        .clk            (clk),
        .reset          (reset),
        .csr_wr_en      (csr_wr_en),
        .csr_addr       (csr_addr),
        .csr_wr_data    (csr_wr_data),
        .test_done      (test_done),
        .csr_rd_data    (csr_rd_data),
        .user_chan_en   (user_chan_en),
        .test_req_mode  (test_req_mode),
        .test_req_count (test_req_count)
    );

    hc_chan_fifo u_rx_fifo (
        .clk       (clk),
        .reset     (reset),
        .push      (host_rx_valid),
        .push_data (host_rx_data),
        .pop       (rx_enable),
        .pop_data  (rx_data),
        .not_empty (rx_rdy),
        .not_full  (rx_not_full)
    );

    hc_chan_fifo u_tx_fifo (
        .clk       (clk),
        .reset     (reset),
        .push      (tx_enable),
        .push_data (tx_data),
        .pop       (tx_pop),
        .pop_data  (host_tx_data),
        .not_empty (host_tx_valid),
        .not_full  (tx_rdy)
    );

    hc_tester u_tester (
        .clk              (clk),
        .reset            (reset),
        .user_chan_en     (user_chan_en),
        .test_req_mode    (test_req_mode),
        .test_req_count   (test_req_count),
        .client_rx_data   (client_rx_data),
        .client_rx_rdy    (client_rx_rdy),
        .client_rx_enable (client_rx_enable),
        .client_tx_data   (client_tx_data),
        .client_tx_rdy    (client_tx_rdy),
        .client_tx_enable (client_tx_enable),
        .rx_data          (rx_data),
        .rx_rdy           (rx_rdy),
        .rx_enable        (rx_enable),
        .tx_data          (tx_data),
        .tx_rdy           (tx_rdy),
        .tx_enable        (tx_enable),
        .test_done        (test_done)
    );

endmodule

// ==== src/hc_csr_regs.sv ====
// Host-channel register block
// Holds the user-channel enable, turns TEST writes into one-cycle
// tester requests and counts completed tests

`timescale 1ns/1ps

module hc_csr_regs
    import hc_cfg_pkg::*;
(
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     csr_wr_en,
    input  logic [HC_CSR_ADDR_W-1:0] csr_addr,
    input  logic [HC_CSR_DATA_W-1:0] csr_wr_data,
    input  logic                     test_done,
    output logic [HC_CSR_DATA_W-1:0] csr_rd_data,
    output logic                     user_chan_en,
    output t_hc_mode                 test_req_mode,
    output logic [HC_COUNT_W-1:0]    test_req_count
);

    logic [HC_DONE_W-1:0] done_count;

    // Control register and test request
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            user_chan_en  <= 1'b0;
            test_req_mode <= NORMAL;
        end
        else
        begin
            // Request lasts one cycle, then drops back to idle
            test_req_mode <= NORMAL;
            if (csr_wr_en && (csr_addr == HC_CSR_CTRL))
                user_chan_en <= csr_wr_data[0];
            if (csr_wr_en && (csr_addr == HC_CSR_TEST))
                test_req_mode <= t_hc_mode'(csr_wr_data[1:0]);
        end
    end

    // Count only matters while a request is up
    always_ff @(posedge clk)
    begin
        if (csr_wr_en && (csr_addr == HC_CSR_TEST))
            test_req_count <= csr_wr_data[HC_COUNT_W+1:2];
    end

    // Completed test counter that wraps
    always_ff @(posedge clk)
    begin
        if (reset)
            done_count <= '0;
        else if (test_done)
            done_count <= done_count + 1'b1;
    end

    // TEST and unmapped addresses read back zero
    always_comb
    begin
        case (csr_addr)
            HC_CSR_CTRL: csr_rd_data = HC_CSR_DATA_W'(user_chan_en);
            HC_CSR_DONE: csr_rd_data = HC_CSR_DATA_W'(done_count);
            default:     csr_rd_data = '0;
        endcase
    end

    // A zero-length source test would never end
    assert property (@(posedge clk) disable iff (reset)
        (test_req_mode == SOURCE) |-> (test_req_count != '0))
        else $error("SOURCE request with zero count");

endmodule

// ==== src/hc_msg_pkg.sv ====
// Host-channel message definitions
// Line format shared by the FIFOs, the tester and the top level

package hc_msg_pkg;

    // One host message line
    localparam int HC_LINE_W = 64;

    // Low 32 bits carry test payload in the test modes,
    // bit 0 marks the last line of a test
    typedef logic [HC_LINE_W-1:0] t_hc_line;

endpackage

// ==== src/hc_tester.sv ====
// Host-channel test node
// Sits between the client and the channel FIFOs. Passes lines through
// in normal mode and runs sink, source or loopback tests on request

`timescale 1ns/1ps

module hc_tester
    import hc_cfg_pkg::*;
    import hc_msg_pkg::*;
(
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  user_chan_en,
    input  t_hc_mode              test_req_mode,
    input  logic [HC_COUNT_W-1:0] test_req_count,

    // Client receive path
    output t_hc_line              client_rx_data,
    output logic                  client_rx_rdy,
    input  logic                  client_rx_enable,

    // Client transmit path
    input  t_hc_line              client_tx_data,
    output logic                  client_tx_rdy,
    input  logic                  client_tx_enable,

    // Receive FIFO side
    input  t_hc_line              rx_data,
    input  logic                  rx_rdy,
    output logic                  rx_enable,

    // Transmit FIFO side
    output t_hc_line              tx_data,
    input  logic                  tx_rdy,
    output logic                  tx_enable,

    output logic                  test_done
);

    t_hc_mode              mode;
    logic [HC_COUNT_W-1:0] source_count;

    // Routing per mode
    always_comb
    begin
        // Data wires follow the normal path unless a test overrides them
        client_rx_data = rx_data;
        tx_data        = client_tx_data;
        client_rx_rdy  = 1'b0;
        client_tx_rdy  = 1'b0;
        rx_enable      = 1'b0;
        tx_enable      = 1'b0;
        test_done      = 1'b0;

        case (mode)
            SINK:
            begin
                // Consume host lines, only while the end line can be sent
                rx_enable = rx_rdy && tx_rdy;
                test_done = rx_enable && rx_data[0];
                // Single line out when the test ends
                tx_enable = test_done;
            end

            SOURCE:
            begin
                // Host lines wait in the receive FIFO
                // Count in the low bits, bit 0 flags the last line
                tx_data[31:0] = {source_count, (source_count == HC_COUNT_W'(1))};
                tx_enable     = tx_rdy;
                test_done     = tx_rdy && (source_count == HC_COUNT_W'(1));
            end

            LOOPBACK:
            begin
                // Take a line only if it can go straight back
                rx_enable     = rx_rdy && tx_rdy;
                tx_data[31:0] = rx_data[31:0];
                tx_enable     = rx_enable;
                test_done     = rx_enable && rx_data[0];
            end

            default:
            begin
                // Plain pass-through
                client_rx_rdy = rx_rdy;
                rx_enable     = client_rx_enable;
                // Client transmit only when the user channel is on
                client_tx_rdy = tx_rdy && user_chan_en;
                tx_enable     = client_tx_enable;
            end
        endcase
    end

    // Source counter
    // reloaded outside SOURCE, stalls under back-pressure
    always_ff @(posedge clk)
    begin
        if (mode != SOURCE)
            source_count <= test_req_count;
        else if (tx_rdy)
            source_count <= source_count - 1'b1;
    end

    // Mode register
    always_ff @(posedge clk)
    begin
        if (reset)
            mode <= NORMAL;
        else if (test_req_mode != NORMAL)
            // Request is held for one cycle only
            mode <= test_req_mode;
        else if (test_done)
            mode <= NORMAL;
    end

    // Holds for the client path too, which relies on the enable protocol
    assert property (@(posedge clk) disable iff (reset) tx_enable |-> tx_rdy)
        else $error("Push into transmit FIFO without tx_rdy");

endmodule
